// File: source/fetch_cfg.svh
////////////////////////////////////////
// Sizes and constants of the fetch subsystem
// Included by the RTL and the testbench
////////////////////////////////////////

`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Number of direct-mapped cache lines with one word each
`define FETCH_LINES 8

// ROM depth in words
// Word addresses wrap modulo this value
`define FETCH_ROM_WORDS 16

// Cycles from a ROM request to its response
`define FETCH_ROM_LATENCY 3

// First fetch address after reset
`define FETCH_RESET_VECTOR 32'h0000_0000

`endif

// File: source/fetch_pkg.sv
////////////////////////////////////////
// Shared types of the fetch subsystem
////////////////////////////////////////

package fetch_pkg;

    // Byte address and instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // Commands from the fetch unit to the instruction cache
    typedef enum logic [1:0] {
        CACHE_NONE      = 2'd0,
        CACHE_EXECUTE   = 2'd1,
        CACHE_FLUSH_ALL = 2'd2
    } cache_cmd_e;

    // Commands from decode back to fetch
    typedef enum logic [1:0] {
        E2F_NONE   = 2'd0,
        E2F_BRANCH = 2'd1,
        E2F_FLUSH  = 2'd2,
        E2F_ABORT  = 2'd3
    } e2f_cmd_e;

    // Kind of record handed to decode
    typedef enum logic {
        F2D_INSTR     = 1'b0,
        F2D_INTERRUPT = 1'b1
    } f2d_type_e;

    typedef struct packed {
        cache_cmd_e cmd;
        addr_t      addr;
    } cache_req_t;

    typedef struct packed {
        logic   done;
        instr_t load_data;
    } cache_rsp_t;

    // Record handed to decode with its kind, word and pc
    typedef struct packed {
        logic      valid;
        f2d_type_e instr_type;
        instr_t    instr;
        addr_t     pc;
    } f2d_t;

    typedef struct packed {
        logic     ready;
        e2f_cmd_e cmd;
        addr_t    branch_target;
    } e2f_t;

endpackage

// File: source/instr_rom.sv
////////////////////////////////////////
// Instruction ROM with a fixed read latency
////////////////////////////////////////

`timescale 1ns/100ps
`include "fetch_cfg.svh"

module instr_rom
    import fetch_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   req,
    input  addr_t  addr,
    output logic   valid,
    output instr_t data
);

    localparam int IDX_W = $clog2(`FETCH_ROM_WORDS);
    localparam int CNT_W = $clog2(`FETCH_ROM_LATENCY + 1);

    instr_t           mem [`FETCH_ROM_WORDS];
    logic [IDX_W-1:0] rd_idx;
    // Cycles left until the response, zero when idle
    logic [CNT_W-1:0] cnt;

    initial begin
        $readmemh("source/instr_rom.hex", mem);
    end

    // Word addresses wrap around the ROM depth
    assign rd_idx = IDX_W'(addr % `FETCH_ROM_WORDS);
    assign valid  = (cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (req) begin
            cnt <= CNT_W'(`FETCH_ROM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Word is read at request time and waits for the counter
    always_ff @(posedge clk) begin
        if (req) begin
            data <= mem[rd_idx];
        end
    end

endmodule

// File: source/instr_cache.sv
////////////////////////////////////////
// Direct-mapped instruction cache with one word per line
// Refills from the instruction ROM on a miss
////////////////////////////////////////

`timescale 1ns/100ps
`include "fetch_cfg.svh"

module instr_cache
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cache_req_t req,
    output cache_rsp_t rsp,
    output logic       rom_req,
    output addr_t      rom_addr,
    input  logic       rom_valid,
    input  instr_t     rom_data
);

    localparam int IDX_W = $clog2(`FETCH_LINES);
    localparam int TAG_W = 32 - 2 - IDX_W;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        FLUSH
    } cache_state_e;

    cache_state_e state;
    cache_state_e state_nxt;

    // Line storage with a valid bit, a tag and a word per line
    logic [`FETCH_LINES-1:0] line_valid;
    logic [TAG_W-1:0]        tag_mem  [`FETCH_LINES];
    instr_t                  data_mem [`FETCH_LINES];

    // The accepted address stays here because the fetch unit may move on in the done cycle
    addr_t            cur_addr;
    logic [IDX_W-1:0] cur_idx;
    logic [TAG_W-1:0] cur_tag;
    logic             hit;
    logic             done;
    logic             accept;

    assign cur_idx = cur_addr[2 +: IDX_W];
    assign cur_tag = cur_addr[31 -: TAG_W];
    assign hit     = line_valid[cur_idx] && (tag_mem[cur_idx] == cur_tag);

    // Lookup that hits or the single flush cycle ends a command
    assign done = ((state == LOOKUP) && hit) || (state == FLUSH);

    // New command is taken when idle or right in the done cycle
    assign accept = ((state == IDLE) || done) && (req.cmd != CACHE_NONE);

    assign rsp.done      = done;
    assign rsp.load_data = data_mem[cur_idx];

    // ROM is addressed in words
    assign rom_addr = {2'b00, cur_addr[31:2]};

    ////////////////////////////////////////
    // Refill state machine
    ////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        rom_req   = 1'b0;
        case (state)
            IDLE: begin
                state_nxt = IDLE;
            end
            LOOKUP: begin
                if (hit) begin
                    state_nxt = IDLE;
                end else begin
                    // One request pulse and then a wait for the word
                    rom_req   = 1'b1;
                    state_nxt = REFILL;
                end
            end
            REFILL: begin
                // Back to lookup which then hits on the new line
                if (rom_valid) begin
                    state_nxt = LOOKUP;
                end
            end
            FLUSH: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
        if (accept) begin
            state_nxt = (req.cmd == CACHE_FLUSH_ALL) ? FLUSH : LOOKUP;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            line_valid <= '0;
        end else begin
            state <= state_nxt;
            if (state == FLUSH) begin
                line_valid <= '0;
            end else if ((state == REFILL) && rom_valid) begin
                line_valid[cur_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_addr <= req.addr;
        end
        if ((state == REFILL) && rom_valid) begin
            tag_mem[cur_idx]  <= cur_tag;
            data_mem[cur_idx] <= rom_data;
        end
    end

endmodule

// File: source/fetch_unit.sv
////////////////////////////////////////
// Fetch control, issues cache commands in program order
// and hands each fetched word to decode as an f2d record
////////////////////////////////////////

`timescale 1ns/100ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      reset_vector,
    output cache_req_t cache_req,
    input  cache_rsp_t cache_rsp,
    input  logic       interrupt_pending,
    input  logic       dbg_mode,
    output logic       busy,
    output f2d_t       f2d,
    input  e2f_t       e2f
);

    // Command in flight and its kind
    logic       active;
    logic       active_nxt;
    cache_cmd_e active_cmd;
    cache_cmd_e active_cmd_nxt;
    // Address of the word in flight or last fetched
    addr_t      pc;
    addr_t      pc_nxt;
    // Branch and flush seen earlier but not yet started
    logic       branched;
    logic       branched_nxt;
    addr_t      branched_target;
    addr_t      branched_target_nxt;
    logic       flushed;
    logic       flushed_nxt;
    // Word that decode did not take yet
    logic       hold_valid;
    logic       hold_valid_nxt;
    instr_t     hold_instr;

    logic       e2f_branch;
    logic       e2f_flush;
    logic       e2f_abort;
    logic       flushing;
    logic       branching;
    addr_t      branching_target;
    logic       exec_done;
    logic       can_start;

    // Decode commands only count while decode is ready
    assign e2f_branch = e2f.ready && (e2f.cmd == E2F_BRANCH);
    assign e2f_flush  = e2f.ready && (e2f.cmd == E2F_FLUSH);
    assign e2f_abort  = e2f.ready && (e2f.cmd == E2F_ABORT);

    // Either remembered from earlier or arriving right now
    assign flushing         = flushed || e2f_flush;
    assign branching        = branched || e2f_branch;
    assign branching_target = e2f_branch ? e2f.branch_target : branched_target;

    assign exec_done = active && cache_rsp.done && (active_cmd == CACHE_EXECUTE);

    // Cache is free and no offered record is left waiting on decode
    assign can_start = (!active || cache_rsp.done) && !(f2d.valid && !e2f.ready);

    assign busy = active || hold_valid;

    ////////////////////////////////////////
    // Record towards decode
    ////////////////////////////////////////

    always_comb begin
        f2d.valid      = 1'b0;
        f2d.instr_type = F2D_INSTR;
        f2d.instr      = cache_rsp.load_data;
        f2d.pc         = pc;
        if (hold_valid) begin
            // A held word always goes first
            f2d.valid = 1'b1;
            f2d.instr = hold_instr;
        end else if (exec_done) begin
            f2d.valid = 1'b1;
        end else if (!active && interrupt_pending) begin
            // Only offered when the fetch path is empty
            f2d.valid      = 1'b1;
            f2d.instr_type = F2D_INTERRUPT;
        end
    end

    ////////////////////////////////////////
    // Next cache command
    ////////////////////////////////////////

    always_comb begin
        cache_req.cmd       = CACHE_NONE;
        cache_req.addr      = pc;
        active_nxt          = active;
        active_cmd_nxt      = active_cmd;
        pc_nxt              = pc;
        // Anything seen from decode is kept until a fetch consumes it
        flushed_nxt         = flushing;
        branched_nxt        = branching;
        branched_target_nxt = branching_target;

        if (active && !cache_rsp.done) begin
            // Hold command and address until the cache is done
            cache_req.cmd = active_cmd;
        end else begin
            active_nxt     = 1'b0;
            active_cmd_nxt = CACHE_NONE;
            if (can_start && !dbg_mode && !e2f_abort) begin
                active_nxt = 1'b1;
                if (flushing) begin
                    // Flush keeps the pc, so fetch carries on after it
                    cache_req.cmd  = CACHE_FLUSH_ALL;
                    active_cmd_nxt = CACHE_FLUSH_ALL;
                    flushed_nxt    = 1'b0;
                end else if (branching) begin
                    cache_req.cmd  = CACHE_EXECUTE;
                    cache_req.addr = branching_target;
                    active_cmd_nxt = CACHE_EXECUTE;
                    pc_nxt         = branching_target;
                    branched_nxt   = 1'b0;
                end else begin
                    cache_req.cmd  = CACHE_EXECUTE;
                    cache_req.addr = pc + 32'd4;
                    active_cmd_nxt = CACHE_EXECUTE;
                    pc_nxt         = pc + 32'd4;
                end
            end
        end
    end

    // A finished word that decode refuses is parked until taken
    always_comb begin
        hold_valid_nxt = hold_valid;
        if (exec_done && !e2f.ready) begin
            hold_valid_nxt = 1'b1;
        end else if (hold_valid && e2f.ready) begin
            hold_valid_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Reset acts as a taken branch to the reset vector
            active          <= 1'b0;
            active_cmd      <= CACHE_NONE;
            pc              <= reset_vector;
            branched        <= 1'b1;
            branched_target <= reset_vector;
            flushed         <= 1'b0;
            hold_valid      <= 1'b0;
        end else begin
            active          <= active_nxt;
            active_cmd      <= active_cmd_nxt;
            pc              <= pc_nxt;
            branched        <= branched_nxt;
            branched_target <= branched_target_nxt;
            flushed         <= flushed_nxt;
            hold_valid      <= hold_valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_done && !e2f.ready) begin
            hold_instr <= cache_rsp.load_data;
        end
    end

endmodule

// File: source/fetch_top.sv
////////////////////////////////////////
// Fetch subsystem top, fetch unit with cache and ROM
////////////////////////////////////////

`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic interrupt_pending,
    input  logic dbg_mode,
    input  e2f_t e2f,
    output f2d_t f2d,
    output logic busy
);

    addr_t      reset_vector;
    cache_req_t cache_req;
    cache_rsp_t cache_rsp;
    // Cache refill port
    logic       rom_req;
    addr_t      rom_addr;
    logic       rom_valid;
    instr_t     rom_data;

    assign reset_vector = `FETCH_RESET_VECTOR;

    fetch_unit u_fetch (
        .clk               (clk),
        .rst_n             (rst_n),
        .reset_vector      (reset_vector),
        .cache_req         (cache_req),
        .cache_rsp         (cache_rsp),
        .interrupt_pending (interrupt_pending),
        .dbg_mode          (dbg_mode),
        .busy              (busy),
        .f2d               (f2d),
        .e2f               (e2f)
    );

    instr_cache u_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (cache_req),
        .rsp       (cache_rsp),
        .rom_req   (rom_req),
        .rom_addr  (rom_addr),
        .rom_valid (rom_valid),
        .rom_data  (rom_data)
    );

    instr_rom u_rom (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (rom_req),
        .addr  (rom_addr),
        .valid (rom_valid),
        .data  (rom_data)
    );

endmodule

// File: sim/fetch_tb.sv
////////////////////////////////////////
// Testbench for the fetch subsystem that acts as decode
// and checks each record against a model of the ROM
////////////////////////////////////////

`timescale 1ns/100ps
`include "fetch_cfg.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int  NROWS      = 11;
    localparam real CLK_PERIOD = 4.0;

    // One stimulus row without its name, which is kept in row_names
    typedef struct packed {
        e2f_cmd_e   cmd;
        addr_t      target;
        logic       intr;
        logic       dbg;
        logic [7:0] count;
        logic       rnd;
    } row_t;

    logic      clk;
    logic      rst_n;
    logic      interrupt_pending;
    logic      dbg_mode;
    e2f_t      e2f;
    f2d_t      f2d;
    logic      busy;

    row_t      rows [NROWS];
    string     row_names [NROWS];
    instr_t    rom_model [`FETCH_ROM_WORDS];

    // Snapshot of the DUT outputs in the current cycle
    f2d_t      cur_rec;
    logic      cur_busy;
    // A refused record has to come back unchanged in the next cycle
    logic      pend;
    f2d_t      pend_rec;
    addr_t     model_pc;
    string     cur_name;
    int        row_idx;
    int        taken;
    // Cycles since the last flush command
    // A refetch after a flush can not come back faster than a miss
    int        gap;
    logic      gap_chk;
    // Strict means the record type must match exp_type
    logic      strict;
    f2d_type_e exp_type;
    int        mismatches;
    int        other_errors;

    fetch_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .interrupt_pending (interrupt_pending),
        .dbg_mode          (dbg_mode),
        .e2f               (e2f),
        .f2d               (f2d),
        .busy              (busy)
    );

    always #(CLK_PERIOD / 2.0) clk = !clk;

    task set_row(input int idx, input string name, input e2f_cmd_e cmd, input addr_t target,
                 input logic intr, input logic dbg, input int count, input logic rnd);
        begin
            row_names[idx]   = name;
            rows[idx].cmd    = cmd;
            rows[idx].target = target;
            rows[idx].intr   = intr;
            rows[idx].dbg    = dbg;
            rows[idx].count  = count[7:0];
            rows[idx].rnd    = rnd;
        end
    endtask

    // Each row picks up the pc where the row before it stopped
    task fill_table;
        begin
            set_row(0, "reset_seq", E2F_NONE, 32'h0, 1'b0, 1'b0, 8, 1'b0);
            set_row(1, "branch_wrap", E2F_BRANCH, 32'h38, 1'b0, 1'b0, 8, 1'b0);
            set_row(2, "stall_random", E2F_NONE, 32'h0, 1'b0, 1'b0, 10, 1'b1);
            set_row(3, "branch_back", E2F_BRANCH, 32'h60, 1'b0, 1'b0, 6, 1'b0);
            set_row(4, "flush_refill", E2F_FLUSH, 32'h0, 1'b0, 1'b0, 4, 1'b1);
            set_row(5, "debug_stop", E2F_NONE, 32'h0, 1'b0, 1'b1, 0, 1'b0);
            set_row(6, "debug_resume", E2F_NONE, 32'h0, 1'b0, 1'b0, 4, 1'b1);
            set_row(7, "intr_abort", E2F_ABORT, 32'h0, 1'b1, 1'b1, 1, 1'b0);
            set_row(8, "intr_branch", E2F_BRANCH, 32'h10, 1'b1, 1'b0, 6, 1'b1);
            set_row(9, "abort_once", E2F_ABORT, 32'h0, 1'b0, 1'b0, 4, 1'b0);
            set_row(10, "final_seq", E2F_NONE, 32'h0, 1'b0, 1'b0, 6, 1'b0);
        end
    endtask

    task report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        begin
            mismatches++;
            $display("mismatch %0s %0s: expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task report_error(input string msg);
        begin
            other_errors++;
            $display("error in %0s: %0s", cur_name, msg);
        end
    endtask

    ////////////////////////////////////////
    // Per-cycle decode behavior
    ////////////////////////////////////////

    // Outputs are read at the drive point, once the edge has settled the registers
    task sample_cycle;
        begin
            @(posedge clk);
            #0.5;
            gap++;
            cur_rec  = f2d;
            cur_busy = busy;
            if (pend) begin
                if (!cur_rec.valid) begin
                    report_error("a refused record was dropped");
                end else begin
                    if (cur_rec.pc != pend_rec.pc)
                        report_mismatch("held pc", pend_rec.pc, cur_rec.pc);
                    if (cur_rec.instr != pend_rec.instr)
                        report_mismatch("held instr", pend_rec.instr, cur_rec.instr);
                end
            end
        end
    endtask

    task take_record;
        begin
            if (strict && (cur_rec.instr_type != exp_type))
                report_mismatch("type", exp_type, cur_rec.instr_type);
            if (!strict && (cur_rec.instr_type == F2D_INTERRUPT) && !rows[row_idx].intr)
                report_error("interrupt record while no interrupt is pending");
            if (cur_rec.instr_type == F2D_INSTR) begin
                if (cur_rec.pc != model_pc)
                    report_mismatch("pc", model_pc, cur_rec.pc);
                if (cur_rec.instr != rom_model[(model_pc >> 2) % `FETCH_ROM_WORDS])
                    report_mismatch("instr", rom_model[(model_pc >> 2) % `FETCH_ROM_WORDS],
                                    cur_rec.instr);
                // Every line is empty after a flush, so the word needs a refill
                if (gap_chk && (gap < `FETCH_ROM_LATENCY + 2))
                    report_error("first record after the flush came without a refill");
                gap_chk  = 1'b0;
                model_pc = model_pc + 32'd4;
            end
            taken++;
        end
    endtask

    // A record is taken when valid meets ready at the next edge
    task drive_decode(input logic ready, input e2f_cmd_e cmd, input addr_t target);
        begin
            e2f.ready         = ready;
            e2f.cmd           = cmd;
            e2f.branch_target = target;
            pend     = cur_rec.valid && !ready && (cur_rec.instr_type == F2D_INSTR);
            pend_rec = cur_rec;
            if (cur_rec.valid && ready)
                take_record();
        end
    endtask

    task run_row;
        int guard;
        begin
            cur_name = row_names[row_idx];
            strict   = 1'b0;
            // Setup cycle with decode stalled while the new modes are applied
            sample_cycle();
            interrupt_pending = rows[row_idx].intr;
            dbg_mode          = rows[row_idx].dbg;
            drive_decode(1'b0, E2F_NONE, '0);

            // Commands go out when the fetch path is empty or a record is offered
            if (rows[row_idx].cmd != E2F_NONE) begin
                sample_cycle();
                while (!cur_rec.valid && cur_busy) begin
                    drive_decode(1'b1, E2F_NONE, '0);
                    sample_cycle();
                end
                drive_decode(1'b1, rows[row_idx].cmd, rows[row_idx].target);
                if (rows[row_idx].cmd == E2F_BRANCH)
                    model_pc = rows[row_idx].target;
                if (rows[row_idx].cmd == E2F_FLUSH) begin
                    gap     = 0;
                    gap_chk = 1'b1;
                end
                // An abort keeps the next fetch from starting in its own cycle
                if (rows[row_idx].cmd == E2F_ABORT) begin
                    sample_cycle();
                    if (cur_busy)
                        report_error("a fetch started in the cycle of the abort");
                    drive_decode(1'b1, E2F_NONE, '0);
                end
            end

            strict   = 1'b1;
            exp_type = (rows[row_idx].intr && rows[row_idx].dbg) ? F2D_INTERRUPT : F2D_INSTR;
            taken    = 0;
            while (taken < rows[row_idx].count) begin
                sample_cycle();
                drive_decode(rows[row_idx].rnd ? (($urandom % 4) != 0) : 1'b1, E2F_NONE, '0);
            end
            strict = 1'b0;

            // Debug mode lets the last fetch finish before the unit goes quiet
            if (rows[row_idx].dbg && !rows[row_idx].intr) begin
                guard = 0;
                sample_cycle();
                while ((cur_rec.valid || cur_busy) && (guard < 16)) begin
                    drive_decode(1'b1, E2F_NONE, '0);
                    sample_cycle();
                    guard++;
                end
                if (cur_rec.valid || cur_busy)
                    report_error("busy did not drop in debug mode");
                drive_decode(1'b1, E2F_NONE, '0);
                repeat (8) begin
                    sample_cycle();
                    if (cur_rec.valid || cur_busy)
                        report_error("fetch activity while stopped in debug mode");
                    drive_decode(1'b1, E2F_NONE, '0);
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        interrupt_pending = 1'b0;
        dbg_mode          = 1'b0;
        e2f               = '0;
        pend              = 1'b0;
        pend_rec          = '0;
        gap               = 0;
        gap_chk           = 1'b0;
        strict            = 1'b0;
        exp_type          = F2D_INSTR;
        mismatches        = 0;
        other_errors      = 0;
        cur_name          = "reset";
        model_pc          = `FETCH_RESET_VECTOR;
        void'($urandom(32'hd4bc));
        $readmemh("source/instr_rom.hex", rom_model);
        fill_table();
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        for (row_idx = 0; row_idx < NROWS; row_idx++)
            run_row();
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if ((mismatches == 0) && (other_errors == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Budget of forty cycles per row plus the reset time
    initial begin
        #((NROWS * 40 + 3) * CLK_PERIOD);
        $display("error: watchdog expired in %0s before the table finished", cur_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: fetch_sub.f
+incdir+source
source/fetch_pkg.sv
source/instr_rom.sv
source/instr_cache.sv
source/fetch_unit.sv
source/fetch_top.sv
sim/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_sub

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/instr_rom.sv
      - source/instr_cache.sv
      - source/fetch_unit.sv
      - source/fetch_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/fetch_tb.sv

// File: source/instr_rom.hex
// One 32-bit instruction word per line, word address 0 first
00500093
00a00113
002081b3
40110233
0041a2b3
00229313
0013d393
00c00413
008404b3
00149513
fff48593
00b56633
00c5f6b3
00d64733
0006c7b3
00000013
